// File: Makefile
# Verilator build and run of the MSX bus-core testbench

VERILATOR ?= verilator
TOP       ?= tb_msx_bus_core
RTL_TOP   ?= msx_bus_core
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: list.f
+incdir+.
msx_bus_pkg.sv
msx_mem_pkg.sv
msx_clock_enable.sv
msx_slot_select.sv
msx_memory_map.sv
msx_mem_arbiter.sv
msx_read_latch.sv
msx_bus_core.sv
tb_msx_bus_core.sv

// File: msx_bus_core.sv
// System-bus core of the MSX machine
// Clock enables, slot selection, memory map, memory arbiter and read latch
`timescale 1ns/1ps

module msx_bus_core
	import msx_bus_pkg::*;
	import msx_mem_pkg::*;
(
	input	logic		clk42m,
	input	logic		ff_reset_n,
	// CPU bus
	input	logic		mreq_n,
	input	logic		iorq_n,
	input	logic		rd_n,
	input	logic		wr_n,
	input	cpu_addr_t	cpu_address,
	input	cpu_data_t	cpu_wdata,
	output	cpu_data_t	cpu_rdata,
	output	logic		cpu_enable,
	output	logic		psg_enable,
	// Host loader
	input	logic		loader_freeze,
	input	logic		loader_req_n,
	input	mem_addr_t	loader_address,
	input	cpu_data_t	loader_wdata,
	// External memory
	output	logic		mem_req,
	output	logic		mem_we,
	output	mem_addr_t	mem_address,
	output	cpu_data_t	mem_wdata,
	input	cpu_data_t	mem_rdata,
	output	logic		mem_busy,
	output	logic		read_done
);
	bus_cycle_e	w_bus_cycle;
	slot_sel_t	w_page_slot;
	slot_sel_t	w_page_sub_slot;
	cpu_data_t	w_reg_rdata;
	logic		w_reg_rdata_en;
	logic		w_map_req_n;
	logic		w_map_we;
	mem_addr_t	w_map_address;
	cpu_data_t	w_map_wdata;
	cpu_data_t	w_mem_read_data;

	// ------------------------------------------------------------
	msx_clock_enable u_clock_enable (
		.clk42m			(clk42m),
		.ff_reset_n		(ff_reset_n),
		.loader_freeze	(loader_freeze),
		.mem_busy		(mem_busy),
		.cpu_enable		(cpu_enable),
		.psg_enable		(psg_enable)
	);

	msx_slot_select u_slot_select (
		.clk42m			(clk42m),
		.ff_reset_n		(ff_reset_n),
		.mreq_n			(mreq_n),
		.iorq_n			(iorq_n),
		.rd_n			(rd_n),
		.wr_n			(wr_n),
		.cpu_address	(cpu_address),
		.cpu_wdata		(cpu_wdata),
		.bus_cycle		(w_bus_cycle),
		.page_slot		(w_page_slot),
		.page_sub_slot	(w_page_sub_slot),
		.reg_rdata		(w_reg_rdata),
		.reg_rdata_en	(w_reg_rdata_en)
	);

	// Window name left open, visible in waveforms only
	msx_memory_map u_memory_map (
		.bus_cycle		(w_bus_cycle),
		.page_slot		(w_page_slot),
		.page_sub_slot	(w_page_sub_slot),
		.cpu_address	(cpu_address),
		.cpu_wdata		(cpu_wdata),
		.loader_freeze	(loader_freeze),
		.loader_req_n	(loader_req_n),
		.loader_address	(loader_address),
		.loader_wdata	(loader_wdata),
		.map_req_n		(w_map_req_n),
		.map_we			(w_map_we),
		.map_address	(w_map_address),
		.map_wdata		(w_map_wdata),
		.map_window		()
	);

	msx_mem_arbiter u_mem_arbiter (
		.clk42m			(clk42m),
		.ff_reset_n		(ff_reset_n),
		.loader_freeze	(loader_freeze),
		.map_req_n		(w_map_req_n),
		.map_we			(w_map_we),
		.map_address	(w_map_address),
		.map_wdata		(w_map_wdata),
		.mem_rdata		(mem_rdata),
		.mem_req		(mem_req),
		.mem_we			(mem_we),
		.mem_address	(mem_address),
		.mem_wdata		(mem_wdata),
		.mem_busy		(mem_busy),
		.read_done		(read_done),
		.mem_read_data	(w_mem_read_data)
	);

	msx_read_latch u_read_latch (
		.clk42m			(clk42m),
		.ff_reset_n		(ff_reset_n),
		.rd_n			(rd_n),
		.read_done		(read_done),
		.mem_read_data	(w_mem_read_data),
		.reg_rdata_en	(w_reg_rdata_en),
		.reg_rdata		(w_reg_rdata),
		.cpu_rdata		(cpu_rdata)
	);

endmodule

// File: msx_bus_pkg.sv
// CPU-side types of the MSX system bus
// Address and data words, slot fields, bus cycles and memory windows
package msx_bus_pkg;

	typedef logic [15:0]	cpu_addr_t;
	typedef logic [7:0]		cpu_data_t;
	typedef logic [1:0]		slot_sel_t;
	typedef logic [7:0]		slot_regs_t;	// Four 2-bit page fields, page 0 in [1:0]

	// Decoded from the CPU strobes
	typedef enum logic [2:0] {
		cyc_idle,
		cyc_mem_read,
		cyc_mem_write,
		cyc_io_read,
		cyc_io_write
	} bus_cycle_e;

	// One entry per memory window
	typedef enum logic [3:0] {
		win_main_rom,
		win_iot_basic,
		win_msx_music,
		win_ext_basic,
		win_mega_1m,
		win_mega_512k,
		win_mapper_ram,
		win_sub_rom,
		win_nextor,
		win_none		// Slot 3-3, nothing mapped
	} rom_window_e;

endpackage

// File: msx_clock_enable.sv
// CPU and sound-chip clock enables
// Counters clear under loader freeze, enables drop while memory is busy
`timescale 1ns/1ps
`include "msx_params.svh"

module msx_clock_enable (
	input	logic	clk42m,
	input	logic	ff_reset_n,
	input	logic	loader_freeze,
	input	logic	mem_busy,
	output	logic	cpu_enable,
	output	logic	psg_enable
);
	localparam int CPU_W = $clog2(`MSX_CPU_DIV);
	localparam int PSG_W = $clog2(`MSX_PSG_DIV);

	logic	[CPU_W-1:0]	ff_cpu_div;
	logic	[PSG_W-1:0]	ff_psg_div;

	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_cpu_div <= '0;
		end else if (loader_freeze) begin
			ff_cpu_div <= '0;								// Parked at zero
		end else if (ff_cpu_div == CPU_W'(`MSX_CPU_DIV - 1)) begin
			ff_cpu_div <= '0;
		end else begin
			ff_cpu_div <= ff_cpu_div + 1'b1;
		end
	end

	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_psg_div <= '0;
		end else if (loader_freeze) begin
			ff_psg_div <= '0;
		end else if (ff_psg_div == PSG_W'(`MSX_PSG_DIV - 1)) begin
			ff_psg_div <= '0;
		end else begin
			ff_psg_div <= ff_psg_div + 1'b1;
		end
	end

	// Busy swallows enables and stalls the CPU
	assign cpu_enable = (ff_cpu_div == CPU_W'(`MSX_CPU_DIV - 1)) && !mem_busy && !loader_freeze;
	assign psg_enable = (ff_psg_div == PSG_W'(`MSX_PSG_DIV - 1)) && !mem_busy && !loader_freeze;

	// Sound enable lands on every second CPU enable
	a_psg_in_phase: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		psg_enable |-> cpu_enable);

endmodule

// File: msx_mem_arbiter.sv
// External memory arbiter
// CPU bus and host loader share one memory, one access of fixed length at a time
// Busy spans the access, read_done follows a CPU read with its data
`timescale 1ns/1ps
`include "msx_params.svh"

module msx_mem_arbiter
	import msx_bus_pkg::*;
	import msx_mem_pkg::*;
(
	input	logic		clk42m,
	input	logic		ff_reset_n,
	input	logic		loader_freeze,
	input	logic		map_req_n,
	input	logic		map_we,
	input	mem_addr_t	map_address,
	input	cpu_data_t	map_wdata,
	input	cpu_data_t	mem_rdata,
	output	logic		mem_req,
	output	logic		mem_we,
	output	mem_addr_t	mem_address,
	output	cpu_data_t	mem_wdata,
	output	logic		mem_busy,
	output	logic		read_done,
	output	cpu_data_t	mem_read_data
);
	localparam int CNT_W = $clog2(`MSX_MEM_ACCESS_CYCLES);

	arb_state_e			ff_state;
	mem_owner_e			ff_owner;
	mem_owner_e			w_owner;
	logic	[CNT_W-1:0]	ff_count;
	logic				ff_req_n_d;
	logic				w_req_fall;
	logic				w_last;
	logic				ff_pending;			// One loader write waiting
	mem_addr_t			ff_pend_address;
	cpu_data_t			ff_pend_wdata;
	logic				ff_req;
	logic				ff_we;
	logic				ff_read_done;
	mem_addr_t			ff_address;
	cpu_data_t			ff_wdata;
	cpu_data_t			ff_read_data;

	assign w_owner		= loader_freeze ? owner_loader : owner_cpu;
	assign w_req_fall	= ff_req_n_d && !map_req_n;
	assign w_last		= (ff_state == arb_access) &&
						  (ff_count == CNT_W'(`MSX_MEM_ACCESS_CYCLES - 1));

	// ------------------------------------------------------------
	// Control FSM
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_state		<= arb_idle;
			ff_owner		<= owner_cpu;
			ff_count		<= '0;
			ff_req_n_d		<= 1'b1;
			ff_pending		<= 1'b0;
			ff_req			<= 1'b0;
			ff_we			<= 1'b0;
			ff_read_done	<= 1'b0;
		end else begin
			ff_req_n_d		<= map_req_n;
			ff_req			<= 1'b0;
			ff_read_done	<= w_last && (ff_owner == owner_cpu) && !ff_we;
			case (ff_state)
				arb_idle: begin
					if (ff_pending || w_req_fall) begin
						ff_state	<= arb_access;
						ff_count	<= '0;
						ff_req		<= 1'b1;
						ff_owner	<= ff_pending ? owner_loader : w_owner;
						ff_we		<= ff_pending ? 1'b1 : map_we;
					end
					ff_pending <= ff_pending && w_req_fall;	// New pulse queues behind
				end
				default: begin
					ff_count <= ff_count + 1'b1;
					if (w_last) begin
						ff_state <= arb_idle;
					end
					if (w_req_fall && w_owner == owner_loader) begin
						ff_pending <= 1'b1;
					end
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	// Address, data and read capture
	always_ff @(posedge clk42m) begin
		if (ff_state == arb_idle && ff_pending) begin
			ff_address	<= ff_pend_address;
			ff_wdata	<= ff_pend_wdata;
		end else if (ff_state == arb_idle && w_req_fall) begin
			ff_address	<= map_address;
			ff_wdata	<= map_wdata;
		end
		if (w_req_fall && (ff_state == arb_access || ff_pending)) begin
			ff_pend_address	<= map_address;
			ff_pend_wdata	<= map_wdata;
		end
		if (w_last) begin
			ff_read_data <= mem_rdata;						// Sampled in last cycle
		end
	end

	assign mem_req			= ff_req;
	assign mem_we			= ff_we;
	assign mem_address		= ff_address;
	assign mem_wdata		= ff_wdata;
	assign mem_busy			= (ff_state == arb_access);
	assign read_done		= ff_read_done;
	assign mem_read_data	= ff_read_data;

	a_req_one_cycle: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		mem_req |=> !mem_req);

	// Owner fixed from request to end of busy
	a_owner_stable: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		(mem_busy && !mem_req) |-> $stable(ff_owner));

endmodule

// File: msx_mem_pkg.sv
// Memory-side types of the MSX system bus
// External memory address, bus owner and arbiter FSM states
package msx_mem_pkg;

	typedef logic [22:0]	mem_addr_t;		// 8MB byte address

	// Who started the access in flight
	typedef enum logic {
		owner_cpu,
		owner_loader
	} mem_owner_e;

	typedef enum logic {
		arb_idle,
		arb_access
	} arb_state_e;

endpackage

// File: msx_memory_map.sv
// Memory map of the MSX bus
// Turns slot, sub-slot and CPU address into a 23-bit external memory address
// Under loader freeze the loader write passes straight through
`timescale 1ns/1ps
`include "msx_params.svh"

module msx_memory_map
	import msx_bus_pkg::*;
	import msx_mem_pkg::*;
(
	input	bus_cycle_e		bus_cycle,
	input	slot_sel_t		page_slot,
	input	slot_sel_t		page_sub_slot,
	input	cpu_addr_t		cpu_address,
	input	cpu_data_t		cpu_wdata,
	input	logic			loader_freeze,
	input	logic			loader_req_n,
	input	mem_addr_t		loader_address,
	input	cpu_data_t		loader_wdata,
	output	logic			map_req_n,
	output	logic			map_we,
	output	mem_addr_t		map_address,
	output	cpu_data_t		map_wdata,
	output	rom_window_e	map_window
);
	rom_window_e	w_window;
	logic	[1:0]	w_page;
	logic			w_mid;				// Pages 1 and 2
	logic	[9:0]	w_upper;
	logic			w_readable;

	assign w_page	= cpu_address[15:14];
	assign w_mid	= (w_page == 2'd1) || (w_page == 2'd2);

	// Window from slot and sub-slot
	always_comb begin
		case ({page_slot, page_sub_slot})
			4'b00_00:	w_window = win_main_rom;
			4'b00_01:	w_window = win_iot_basic;
			4'b00_10:	w_window = win_msx_music;
			4'b00_11:	w_window = win_ext_basic;
			4'b11_00:	w_window = win_mapper_ram;
			4'b11_01:	w_window = win_sub_rom;
			4'b11_10:	w_window = win_nextor;
			4'b11_11:	w_window = win_none;
			default:	w_window = (page_slot == 2'd1) ? win_mega_1m : win_mega_512k;
		endcase
	end

	// ------------------------------------------------------------
	// Upper address bits and readable pages per window
	always_comb begin
		w_upper		= 10'd0;
		w_readable	= 1'b0;
		case (w_window)
			win_main_rom: begin
				w_upper		= {`MSX_BASE_MAIN_ROM, cpu_address[14:13]};
				w_readable	= !cpu_address[15];
			end
			win_iot_basic: begin
				w_upper		= {`MSX_BASE_IOT_BASIC, cpu_address[13]};
				w_readable	= (w_page == 2'd1);
			end
			win_msx_music: begin
				w_upper		= {`MSX_BASE_MSX_MUSIC, cpu_address[13]};
				w_readable	= (w_page == 2'd1);
			end
			win_ext_basic: begin
				w_upper		= {`MSX_BASE_EXT_BASIC, cpu_address[14:13]};	// Logo too
				w_readable	= w_mid;
			end
			win_mega_1m: begin
				w_upper		= {`MSX_BASE_MEGA_1M, ~cpu_address[14], cpu_address[13]};
				w_readable	= w_mid;
			end
			win_mega_512k: begin
				w_upper		= `MSX_BASE_MEGA_512K;
				w_readable	= w_mid;
			end
			win_mapper_ram: begin
				w_upper		= {`MSX_BASE_MAPPER_RAM, cpu_address[15:13]};
				w_readable	= 1'b1;									// Whole 64KB
			end
			win_sub_rom: begin
				w_upper		= {`MSX_BASE_SUB_ROM, cpu_address[14:13]};
				w_readable	= !cpu_address[15];
			end
			win_nextor: begin
				w_upper		= {`MSX_BASE_NEXTOR, cpu_address[15:13]};
				w_readable	= w_mid;
			end
			default: begin
				w_upper		= 10'd0;								// Slot 3-3 empty
				w_readable	= 1'b0;
			end
		endcase
	end

	// ------------------------------------------------------------
	// Request to the arbiter
	always_comb begin
		if (loader_freeze) begin
			map_req_n	= loader_req_n;
			map_we		= 1'b1;										// Loader only writes
			map_address	= loader_address;
			map_wdata	= loader_wdata;
			map_window	= win_none;
		end else begin
			map_req_n	= !((bus_cycle == cyc_mem_read && w_readable) ||
							(bus_cycle == cyc_mem_write && w_window == win_mapper_ram));
			map_we		= (bus_cycle == cyc_mem_write);
			map_address	= {w_upper, cpu_address[12:0]};
			map_wdata	= cpu_wdata;
			map_window	= w_window;
		end
	end

endmodule

// File: msx_params.svh
// System-bus constants of the MSX core
// Divider ratios, port and register addresses, memory timing, window bases
`ifndef MSX_PARAMS_SVH
`define MSX_PARAMS_SVH

// ------------------------------------------------------------
// Clock enables
`define MSX_CPU_DIV				6			// CPU enable every 6 clocks
`define MSX_PSG_DIV				12			// Sound chip at half CPU rate

// I/O port and memory-mapped register
`define MSX_PPI_PORT			8'hA8		// Decode A8h-ABh, register at A8h only
`define MSX_EXP_SLOT_ADDR		16'hFFFF

// Memory bus
`define MSX_MEM_ACCESS_CYCLES	4			// Cycles from request to end of busy
`define MSX_IDLE_DATA			8'hFF		// Undriven data bus

// ------------------------------------------------------------
// Window bases, upper bits of the 23-bit memory address
`define MSX_BASE_MAIN_ROM		8'b00000100		// + a[14:13]
`define MSX_BASE_IOT_BASIC		9'b000001100	// + a[13]
`define MSX_BASE_MSX_MUSIC		9'b000001101	// + a[13]
`define MSX_BASE_EXT_BASIC		8'b00000111		// + a[14:13]
`define MSX_BASE_MEGA_1M		8'b01000000		// + ~a[14], a[13]
`define MSX_BASE_MEGA_512K		10'b0000100000	// Fixed bank
`define MSX_BASE_MAPPER_RAM		7'b1000000		// + a[15:13]
`define MSX_BASE_SUB_ROM		8'b00000101		// + a[14:13]
`define MSX_BASE_NEXTOR			7'b0000000		// + a[15:13]

`endif

// File: msx_read_latch.sv
// CPU read-data latch
// Memory data wins over register data, idle value while no read is active
`timescale 1ns/1ps
`include "msx_params.svh"

module msx_read_latch
	import msx_bus_pkg::*;
(
	input	logic		clk42m,
	input	logic		ff_reset_n,
	input	logic		rd_n,
	input	logic		read_done,
	input	cpu_data_t	mem_read_data,
	input	logic		reg_rdata_en,
	input	cpu_data_t	reg_rdata,
	output	cpu_data_t	cpu_rdata
);
	cpu_data_t	ff_rdata;

	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_rdata <= `MSX_IDLE_DATA;
		end else if (read_done) begin
			ff_rdata <= mem_read_data;
		end else if (reg_rdata_en) begin
			ff_rdata <= reg_rdata;
		end else if (rd_n) begin
			ff_rdata <= `MSX_IDLE_DATA;						// Bus floats high
		end
	end

	assign cpu_rdata = ff_rdata;

endmodule

// File: msx_slot_select.sv
// Slot selection of the MSX bus
// Primary slot register at port A8h, secondary registers of slots 0 and 3 at FFFFh
// Gives the slot and sub-slot of the page under the CPU address
`timescale 1ns/1ps
`include "msx_params.svh"

module msx_slot_select
	import msx_bus_pkg::*;
(
	input	logic		clk42m,
	input	logic		ff_reset_n,
	input	logic		mreq_n,
	input	logic		iorq_n,
	input	logic		rd_n,
	input	logic		wr_n,
	input	cpu_addr_t	cpu_address,
	input	cpu_data_t	cpu_wdata,
	output	bus_cycle_e	bus_cycle,
	output	slot_sel_t	page_slot,
	output	slot_sel_t	page_sub_slot,
	output	cpu_data_t	reg_rdata,
	output	logic		reg_rdata_en
);
	bus_cycle_e	w_cycle;
	slot_regs_t	ff_primary;
	slot_regs_t	ff_sec0;
	slot_regs_t	ff_sec3;
	slot_sel_t	w_page3_slot;
	slot_regs_t	w_sec_sel;			// Secondary register seen at FFFFh
	logic		w_ppi_cs;
	logic		w_ppi_reg;
	logic		w_exp_hit;
	logic		w_reg_read;
	cpu_data_t	ff_reg_rdata;
	logic		ff_reg_rdata_en;

	// ------------------------------------------------------------
	// Strobe decode
	always_comb begin
		if (!mreq_n && !rd_n) begin
			w_cycle = cyc_mem_read;
		end else if (!mreq_n && !wr_n) begin
			w_cycle = cyc_mem_write;
		end else if (!iorq_n && !rd_n) begin
			w_cycle = cyc_io_read;
		end else if (!iorq_n && !wr_n) begin
			w_cycle = cyc_io_write;
		end else begin
			w_cycle = cyc_idle;
		end
	end

	assign w_ppi_cs		= (w_cycle == cyc_io_read || w_cycle == cyc_io_write) &&
						  ({cpu_address[7:2], 2'b00} == `MSX_PPI_PORT);
	assign w_ppi_reg	= w_ppi_cs && (cpu_address[1:0] == 2'b00);	// Port A only
	assign w_page3_slot	= ff_primary[7:6];
	assign w_sec_sel	= (w_page3_slot == 2'd3) ? ff_sec3 : ff_sec0;
	assign w_exp_hit	= (w_cycle == cyc_mem_read || w_cycle == cyc_mem_write) &&
						  (cpu_address == `MSX_EXP_SLOT_ADDR) &&
						  (w_page3_slot == 2'd0 || w_page3_slot == 2'd3);

	// FFFFh register access hides the memory cycle behind it
	assign bus_cycle	= w_exp_hit ? cyc_idle : w_cycle;

	// ------------------------------------------------------------
	// Slot registers
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_primary	<= '0;
			ff_sec0		<= '0;
			ff_sec3		<= '0;
		end else begin
			if (w_ppi_reg && w_cycle == cyc_io_write) begin
				ff_primary <= cpu_wdata;
			end
			if (w_exp_hit && w_cycle == cyc_mem_write) begin
				if (w_page3_slot == 2'd0) begin
					ff_sec0 <= cpu_wdata;
				end else begin
					ff_sec3 <= cpu_wdata;
				end
			end
		end
	end

	// Page under the CPU address
	always_comb begin
		page_slot = ff_primary[{cpu_address[15:14], 1'b0} +: 2];
		case (page_slot)
			2'd0:		page_sub_slot = ff_sec0[{cpu_address[15:14], 1'b0} +: 2];
			2'd3:		page_sub_slot = ff_sec3[{cpu_address[15:14], 1'b0} +: 2];
			default:	page_sub_slot = 2'd0;				// Slots 1 and 2 not expanded
		endcase
	end

	// ------------------------------------------------------------
	// Read-back, valid from the cycle after the strobe falls
	assign w_reg_read = (w_ppi_reg && w_cycle == cyc_io_read) ||
						(w_exp_hit && w_cycle == cyc_mem_read);

	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_reg_rdata_en <= 1'b0;
		end else begin
			ff_reg_rdata_en <= w_reg_read;
		end
	end

	always_ff @(posedge clk42m) begin
		if (w_reg_read) begin
			ff_reg_rdata <= w_exp_hit ? ~w_sec_sel : ff_primary;	// FFFFh reads back inverted
		end
	end

	assign reg_rdata	= ff_reg_rdata;
	assign reg_rdata_en	= ff_reg_rdata_en;

	a_rd_wr_exclusive: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		!(!rd_n && !wr_n));

endmodule

// File: tb_msx_bus_core.sv
// Testbench of the MSX system-bus core
// Plays CPU, host loader and external memory, table of slot and window checks
`timescale 1ns/1ps
`include "msx_params.svh"

module tb_msx_bus_core
	import msx_bus_pkg::*;
	import msx_mem_pkg::*;
;
	localparam int MAX_ENTRIES = 24;

	typedef enum logic {
		op_read,
		op_write
	} tb_op_e;

	logic		clk42m;
	logic		ff_reset_n;
	logic		mreq_n;
	logic		iorq_n;
	logic		rd_n;
	logic		wr_n;
	cpu_addr_t	cpu_address;
	cpu_data_t	cpu_wdata;
	cpu_data_t	cpu_rdata;
	logic		cpu_enable;
	logic		psg_enable;
	logic		loader_freeze;
	logic		loader_req_n;
	mem_addr_t	loader_address;
	cpu_data_t	loader_wdata;
	logic		mem_req;
	logic		mem_we;
	mem_addr_t	mem_address;
	cpu_data_t	mem_wdata;
	cpu_data_t	mem_rdata;
	logic		mem_busy;
	logic		read_done;

	// Memory model and bus monitor state
	cpu_data_t	mem_model [mem_addr_t];
	int			req_count;
	mem_addr_t	last_req_addr;
	logic		last_req_we;
	int			cpu_en_count;
	int			psg_en_count;
	int			busy_run;

	// Stimulus table
	tb_op_e		tbl_op [MAX_ENTRIES];
	cpu_data_t	tbl_pri [MAX_ENTRIES];
	cpu_data_t	tbl_sec [MAX_ENTRIES];
	cpu_addr_t	tbl_addr [MAX_ENTRIES];
	cpu_data_t	tbl_data [MAX_ENTRIES];
	mem_addr_t	tbl_exp [MAX_ENTRIES];
	logic		tbl_hit [MAX_ENTRIES];
	int			n_entries;

	msx_bus_core msx_bus_core_i (.*);

	initial begin
		clk42m = 1'b0;
		forever #20 clk42m = ~clk42m;						// 25 MHz stand-in
	end

	// ------------------------------------------------------------
	// Fill pattern of unwritten memory, xorshift over the address
	function automatic cpu_data_t fill_byte(input mem_addr_t a);
		logic [31:0] x;
		x = 32'd86 ^ {9'd0, a};
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x[7:0] ^ x[15:8] ^ x[23:16];
	endfunction

	function automatic cpu_data_t model_read(input mem_addr_t a);
		if (mem_model.exists(a)) begin
			return mem_model[a];
		end
		return fill_byte(a);
	endfunction

	// Model writes in the request cycle, read data follows the address
	always @(negedge clk42m) begin
		if (mem_req) begin
			req_count		= req_count + 1;
			last_req_addr	= mem_address;
			last_req_we		= mem_we;
			if (mem_we) begin
				mem_model[mem_address] = mem_wdata;
			end
		end
		mem_rdata = model_read(mem_address);
		if (cpu_enable) cpu_en_count = cpu_en_count + 1;
		if (psg_enable) psg_en_count = psg_en_count + 1;
		if (ff_reset_n && mem_busy && cpu_enable) begin
			$display("CPU enable pulsed while memory was busy at %0t", $time);
			report_fail();
		end
		// read_done only for a CPU read, right behind busy
		if (read_done && rd_n) begin
			$display("read_done pulsed with no CPU read active at %0t", $time);
			report_fail();
		end
		if (read_done) begin
			check_count("busy before read_done", busy_run, `MSX_MEM_ACCESS_CYCLES);
		end
		// Access length from mem_req to the end of busy
		if (mem_req) begin
			check_count("mem_busy at mem_req", int'(mem_busy), 1);
			busy_run = 0;
		end
		if (mem_busy) begin
			busy_run = busy_run + 1;
		end else if (busy_run != 0) begin
			check_count("mem_busy cycles", busy_run, `MSX_MEM_ACCESS_CYCLES);
			busy_run = 0;
		end
	end

	// ------------------------------------------------------------
	// Failure reporting and compares
	task automatic report_fail();
		$display("ERRORS FOUND");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic check_data(input string name, input cpu_data_t got, input cpu_data_t exp);
		if (got !== exp) begin
			$display("Fail %0t %s got %h expected %h", $time, name, got, exp);
			report_fail();
		end
	endtask

	task automatic check_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
		if (got !== exp) begin
			$display("Fail %0t %s got %h expected %h", $time, name, got, exp);
			report_fail();
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("Fail %0t %s got %0d expected %0d", $time, name, got, exp);
			report_fail();
		end
	endtask

	// Just past the falling edge, monitor already updated
	task automatic sample_point();
		@(negedge clk42m);
		#1;
	endtask

	task automatic wait_idle(input string what);
		int n;
		n = 0;
		while (mem_busy && n < 20) begin
			sample_point();
			n++;
		end
		if (mem_busy) begin
			$display("Memory stayed busy after %s", what);
			report_fail();
		end
	endtask

	// ------------------------------------------------------------
	// CPU bus cycles
	task automatic release_bus();
		@(posedge clk42m);
		mreq_n	<= 1'b1;
		iorq_n	<= 1'b1;
		rd_n	<= 1'b1;
		wr_n	<= 1'b1;
		repeat (2) @(posedge clk42m);
	endtask

	task automatic io_write(input logic [7:0] port, input cpu_data_t data);
		@(posedge clk42m);
		iorq_n		<= 1'b0;
		wr_n		<= 1'b0;
		cpu_address	<= {8'h00, port};
		cpu_wdata	<= data;
		@(posedge clk42m);
		release_bus();
	endtask

	// A8h or FFFFh read-back, fixed two-cycle latency
	task automatic reg_read(input logic is_io, input cpu_addr_t addr, input cpu_data_t exp);
		int base;
		base = req_count;
		@(posedge clk42m);
		iorq_n		<= !is_io;
		mreq_n		<= is_io;
		rd_n		<= 1'b0;
		cpu_address	<= addr;
		repeat (2) @(posedge clk42m);
		sample_point();
		check_data("cpu_rdata", cpu_rdata, exp);
		check_count("mem_req count", req_count - base, 0);
		release_bus();
	endtask

	task automatic mem_read(input cpu_addr_t addr, input logic hit, input mem_addr_t exp_addr,
							input cpu_data_t exp_data);
		int base;
		int n;
		base = req_count;
		n = 0;
		@(posedge clk42m);
		mreq_n		<= 1'b0;
		rd_n		<= 1'b0;
		cpu_address	<= addr;
		if (hit) begin
			sample_point();
			while (!read_done && n < 20) begin
				sample_point();
				n++;
			end
			if (!read_done) begin
				$display("No read_done for CPU read at %h", addr);
				report_fail();
			end
			sample_point();
			check_count("mem_req count", req_count - base, 1);
			check_addr("mem_address", last_req_addr, exp_addr);
			check_count("mem_we", int'(last_req_we), 0);
			check_data("cpu_rdata", cpu_rdata, exp_data);
		end else begin
			repeat (8) sample_point();
			check_count("mem_req count", req_count - base, 0);
			check_data("cpu_rdata", cpu_rdata, `MSX_IDLE_DATA);
		end
		release_bus();
		sample_point();
		check_data("cpu_rdata", cpu_rdata, `MSX_IDLE_DATA);	// rd_n high again
	endtask

	task automatic mem_write(input cpu_addr_t addr, input cpu_data_t data, input logic hit,
							 input mem_addr_t exp_addr);
		int base;
		int n;
		base = req_count;
		n = 0;
		@(posedge clk42m);
		mreq_n		<= 1'b0;
		wr_n		<= 1'b0;
		cpu_address	<= addr;
		cpu_wdata	<= data;
		if (hit) begin
			sample_point();
			while (req_count == base && n < 20) begin
				sample_point();
				n++;
			end
			check_count("mem_req count", req_count - base, 1);
			check_addr("mem_address", last_req_addr, exp_addr);
			check_count("mem_we", int'(last_req_we), 1);
			wait_idle("CPU write");
			check_data("memory", model_read(exp_addr), data);
		end else begin
			repeat (8) sample_point();
			check_count("mem_req count", req_count - base, 0);
		end
		release_bus();
	endtask

	// Secondary register first, through page 3, then the final primary
	task automatic setup_slots(input cpu_data_t pri, input cpu_data_t sec);
		if (pri[1:0] == 2'd0 || pri[1:0] == 2'd3) begin
			io_write(`MSX_PPI_PORT, {pri[1:0], 6'b000000});
			mem_write(`MSX_EXP_SLOT_ADDR, sec, 1'b0, '0);
		end
		io_write(`MSX_PPI_PORT, pri);
	endtask

	task automatic loader_write(input mem_addr_t addr, input cpu_data_t data);
		@(posedge clk42m);
		loader_req_n	<= 1'b0;
		loader_address	<= addr;
		loader_wdata	<= data;
		@(posedge clk42m);
		loader_req_n	<= 1'b1;
	endtask

	task automatic add_entry(input tb_op_e op, input cpu_data_t pri, input cpu_data_t sec,
							 input cpu_addr_t addr, input cpu_data_t data, input logic hit,
							 input mem_addr_t exp);
		tbl_op[n_entries]	= op;
		tbl_pri[n_entries]	= pri;
		tbl_sec[n_entries]	= sec;
		tbl_addr[n_entries]	= addr;
		tbl_data[n_entries]	= data;
		tbl_hit[n_entries]	= hit;
		tbl_exp[n_entries]	= exp;
		n_entries++;
	endtask

	// ------------------------------------------------------------
	// Watchdog, sized from the table plus the fixed tests
	initial begin
		#1;
		repeat ((n_entries + 20) * 40) @(posedge clk42m);
		$display("Timeout: the tests did not finish in time");
		$display("ERRORS FOUND");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		ff_reset_n		= 1'b0;
		mreq_n			= 1'b1;
		iorq_n			= 1'b1;
		rd_n			= 1'b1;
		wr_n			= 1'b1;
		cpu_address		= '0;
		cpu_wdata		= '0;
		loader_freeze	= 1'b0;
		loader_req_n	= 1'b1;
		loader_address	= '0;
		loader_wdata	= '0;
		mem_rdata		= '0;
		req_count		= 0;
		last_req_addr	= '0;
		last_req_we		= 1'b0;
		cpu_en_count	= 0;
		psg_en_count	= 0;
		busy_run		= 0;
		n_entries		= 0;

		// Op, primary, secondary, address, data, hit, memory address
		add_entry(op_read, 8'h00, 8'h00, 16'h2345, 8'h00, 1'b1, {10'b0000010001, 13'h0345});
		add_entry(op_read, 8'h00, 8'h00, 16'h8000, 8'h00, 1'b0, '0);	// Main ROM page 2
		add_entry(op_read, 8'h00, 8'h55, 16'h6001, 8'h00, 1'b1, {10'b0000011001, 13'h0001});
		add_entry(op_read, 8'h00, 8'hAA, 16'h4ABC, 8'h00, 1'b1, {10'b0000011010, 13'h0ABC});
		add_entry(op_read, 8'h00, 8'hFF, 16'hA123, 8'h00, 1'b1, {10'b0000011101, 13'h0123});
		add_entry(op_read, 8'h55, 8'h00, 16'h4010, 8'h00, 1'b1, {10'b0100000000, 13'h0010});
		add_entry(op_read, 8'h55, 8'h00, 16'hA010, 8'h00, 1'b1, {10'b0100000011, 13'h0010});
		add_entry(op_read, 8'hAA, 8'h00, 16'h5555, 8'h00, 1'b1, {10'b0000100000, 13'h1555});
		add_entry(op_read, 8'hAA, 8'h00, 16'h0100, 8'h00, 1'b0, '0);	// 512K page 0
		add_entry(op_read, 8'hFF, 8'h00, 16'hE000, 8'h00, 1'b1, {10'b1000000111, 13'h0000});
		add_entry(op_read, 8'hFF, 8'h55, 16'h3FFF, 8'h00, 1'b1, {10'b0000010101, 13'h1FFF});
		add_entry(op_read, 8'hFF, 8'hAA, 16'h8888, 8'h00, 1'b1, {10'b0000000100, 13'h0888});
		add_entry(op_read, 8'hFF, 8'hFF, 16'h4000, 8'h00, 1'b0, '0);	// Slot 3-3 empty
		add_entry(op_write, 8'hFF, 8'h00, 16'h1234, 8'h5A, 1'b1, {10'b1000000000, 13'h1234});
		add_entry(op_read, 8'hFF, 8'h00, 16'h1234, 8'h00, 1'b1, {10'b1000000000, 13'h1234});
		add_entry(op_write, 8'h00, 8'h00, 16'h1000, 8'hC3, 1'b0, '0);	// ROM write dropped

		repeat (5) @(posedge clk42m);
		ff_reset_n <= 1'b1;
		sample_point();
		check_data("cpu_rdata", cpu_rdata, `MSX_IDLE_DATA);
		check_count("mem_busy", int'(mem_busy), 0);

		// Enable rates while idle, then none under freeze
		@(posedge clk42m);
		cpu_en_count = 0;
		psg_en_count = 0;
		repeat (120) @(posedge clk42m);
		check_count("cpu_enable pulses", cpu_en_count, 120 / `MSX_CPU_DIV);
		check_count("psg_enable pulses", psg_en_count, 120 / `MSX_PSG_DIV);
		loader_freeze <= 1'b1;
		@(posedge clk42m);
		cpu_en_count = 0;
		psg_en_count = 0;
		repeat (60) @(posedge clk42m);
		check_count("cpu_enable pulses", cpu_en_count, 0);
		check_count("psg_enable pulses", psg_en_count, 0);
		loader_freeze <= 1'b0;

		// Primary slot register read-back
		io_write(`MSX_PPI_PORT, 8'h9C);
		reg_read(1'b1, 16'h00A8, 8'h9C);

		// Secondary registers of slots 0 and 3, read back inverted
		io_write(`MSX_PPI_PORT, 8'h00);
		mem_write(`MSX_EXP_SLOT_ADDR, 8'h1B, 1'b0, '0);
		reg_read(1'b0, `MSX_EXP_SLOT_ADDR, 8'hE4);
		io_write(`MSX_PPI_PORT, 8'hC0);
		mem_write(`MSX_EXP_SLOT_ADDR, 8'h2D, 1'b0, '0);
		reg_read(1'b0, `MSX_EXP_SLOT_ADDR, 8'hD2);

		for (int i = 0; i < n_entries; i++) begin
			setup_slots(tbl_pri[i], tbl_sec[i]);
			if (tbl_op[i] == op_read) begin
				mem_read(tbl_addr[i], tbl_hit[i], tbl_exp[i], model_read(tbl_exp[i]));
			end else begin
				mem_write(tbl_addr[i], tbl_data[i], tbl_hit[i], tbl_exp[i]);
			end
		end

		// Loader writes, second one queued behind the first
		@(posedge clk42m);
		loader_freeze <= 1'b1;
		repeat (2) @(posedge clk42m);
		loader_write({7'b1000000, 16'h4100}, 8'hA5);
		loader_write({7'b1000000, 16'hC200}, 8'h3C);
		repeat (2) sample_point();
		wait_idle("first loader write");
		sample_point();
		wait_idle("queued loader write");
		check_data("memory", model_read({7'b1000000, 16'h4100}), 8'hA5);
		check_data("memory", model_read({7'b1000000, 16'hC200}), 8'h3C);
		@(posedge clk42m);
		loader_freeze <= 1'b0;
		setup_slots(8'hFF, 8'h00);
		mem_read(16'h4100, 1'b1, {7'b1000000, 16'h4100}, 8'hA5);
		mem_read(16'hC200, 1'b1, {7'b1000000, 16'hC200}, 8'h3C);

		$display("NO ERRORS");
		$finish;
	end

endmodule
